// ==== compile.f ====
+incdir+include
rtl/obj_pkg.sv
rtl/video_pkg.sv
rtl/obj_tile_draw.sv
rtl/obj_line_buffer.sv
rtl/obj_draw_top.sv
sim/obj_draw_checker.sv
sim/tb_obj_draw.sv

// ==== run.sh ====
#!/bin/sh
# build and run the sprite drawer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module tb_obj_draw \
    -Mdir obj_dir -o sim_obj_draw

./obj_dir/sim_obj_draw > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

// ==== sim/tb_obj_draw.sv ====
`include "obj_draw_macros.svh"

module tb_obj_draw;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_TESTS  = 6;
    localparam int WAIT_MAX = 64;   // cycles any single handshake may take

    logic               clk = 1'b0;
    logic               rst;
    logic               pxl_cen;
    logic               hs;
    logic               flip;
    video_pkg::hpos_t   hdump;
    logic               draw;
    obj_pkg::code_t     code;
    video_pkg::hpos_t   xpos;
    obj_pkg::row_t      ysub;
    logic               hflip;
    logic               vflip;
    obj_pkg::pal_t      pal;
    logic               busy;
    obj_pkg::rom_addr_t rom_addr;
    logic               rom_cs;
    logic               rom_ok   = 1'b0;
    logic [31:0]        rom_data = '0;
    video_pkg::pixel_t  pxl;

    logic [31:0] stim_seed = 32'd48;
    logic [31:0] rom_seed;
    int          rom_wait  = -1;     // cycles left before rom_ok, -1 when no fetch is open
    int          sweeps    = 0;

    always #10 clk = ~clk;

    obj_draw_top #(.LATCH(0), .HJUMP(0)) i_obj_draw_top (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .hs(hs), .flip(flip), .hdump(hdump),
        .draw(draw), .code(code), .xpos(xpos), .ysub(ysub), .hflip(hflip),
        .vflip(vflip), .pal(pal), .busy(busy), .rom_addr(rom_addr), .rom_cs(rom_cs),
        .rom_ok(rom_ok), .rom_data(rom_data), .pxl(pxl)
    );

    obj_draw_checker i_check (
        .clk(clk), .rst(rst), .draw(draw), .busy(busy), .code(code), .xpos(xpos),
        .ysub(ysub), .hflip(hflip), .vflip(vflip), .pal(pal), .rom_cs(rom_cs),
        .hs(hs), .flip(flip), .pxl_cen(pxl_cen), .hdump(hdump), .pxl(pxl)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic rand32(output logic [31:0] r);
        stim_seed = xorshift32(stim_seed);
        r = stim_seed;
    endtask

    // gfx rom, answers 0 to 5 cycles after rom_cs
    always @(negedge clk) begin
        if (rst) begin
            rom_ok <= 1'b0;
            rom_wait = -1;
        end else if (rom_ok) begin
            rom_ok <= 1'b0;                          // taken at the last rising edge
        end else if (rom_cs) begin
            if (rom_wait < 0) begin
                rom_seed = xorshift32(rom_seed);
                rom_wait = int'(rom_seed % 6);
            end
            if (rom_wait == 0) begin
                rom_ok   <= 1'b1;
                rom_data <= i_check.rom_word(rom_addr);
                rom_wait = -1;
            end else begin
                rom_wait--;
            end
        end
    end

    task automatic wait_busy(input logic level, input string what);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (busy !== level && n < WAIT_MAX);
        if (busy !== level)
            i_check.note_error($sformatf("busy not %0b after %0d cycles %s", level, n, what));
    endtask

    // times > 1 keeps draw high, the drawer takes it again once busy falls
    task automatic send_sprite(input obj_pkg::code_t c, input video_pkg::hpos_t x,
            input obj_pkg::row_t y, input logic hf, input logic vf,
            input obj_pkg::pal_t p, input int times);
        if (busy) wait_busy(1'b0, "waiting for the drawer to go idle");
        code  = c;
        xpos  = x;
        ysub  = y;
        hflip = hf;
        vflip = vf;
        pal   = p;
        draw  = 1'b1;
        for (int i = 0; i < times; i++) begin
            if (i > 0) wait_busy(1'b0, "with draw held high");
            wait_busy(1'b1, "waiting for the draw to be taken");
        end
        draw = 1'b0;
    endtask

    task automatic send_random(input video_pkg::hpos_t x, input logic hf, input logic vf,
            input int times);
        logic [31:0] r;
        rand32(r);
        send_sprite(r[`OBJ_CW-1:0], x, r[27:24], hf, vf, r[31:28], times);
    endtask

    // hs pulse, then one full sweep of hdump with pxl_cen on every clock
    task automatic line_end(input logic flp);
        if (busy) wait_busy(1'b0, "before the end of the line");
        flip = flp;
        hs   = 1'b1;
        @(negedge clk);
        hs = 1'b0;
        for (int h = 0; h < `OBJ_BUF_DEPTH; h++) begin
            @(negedge clk);
            hdump   = video_pkg::hpos_t'(h);
            pxl_cen = 1'b1;
        end
        @(negedge clk);
        pxl_cen = 1'b0;
        @(negedge clk);                              // last pixel compared by now
        flip = 1'b0;
        sweeps++;
    endtask

    initial begin
        logic [31:0] r;
        int          acc0;
        rst     = 1'b1;
        pxl_cen = 1'b0;
        hs      = 1'b0;
        flip    = 1'b0;
        hdump   = '0;
        draw    = 1'b0;
        code    = '0;
        xpos    = '0;
        ysub    = '0;
        hflip   = 1'b0;
        vflip   = 1'b0;
        pal     = '0;
        rom_seed = xorshift32(32'd48);               // own stream for rom delays
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (pxl !== video_pkg::PXL_BLANK) i_check.note_error("pxl is not all ones after reset");

        i_check.begin_test("single");
        rand32(r);
        send_sprite(r[`OBJ_CW-1:0], 9'd200, r[27:24], 1'b0, 1'b0, r[31:28], 1);
        line_end(1'b0);

        i_check.begin_test("flips");
        rand32(r);
        for (int f = 0; f < 4; f++) begin            // same row, every flip pair
            send_sprite(r[`OBJ_CW-1:0], 9'(40 + 60 * f), r[27:24], f[0], f[1], 4'(f), 1);
        end
        line_end(1'b0);

        i_check.begin_test("overlap");
        send_random(9'd300, 1'b0, 1'b0, 1);
        send_random(9'd306, 1'b1, 1'b0, 1);
        send_random(9'd310, 1'b0, 1'b1, 1);
        line_end(1'b0);

        i_check.begin_test("erase");
        line_end(1'b0);                              // nothing drawn on either bank
        line_end(1'b1);

        i_check.begin_test("rom_wait");
        acc0 = i_check.accepts;
        for (int i = 0; i < 4; i++) begin
            rand32(r);
            send_random(r[8:0], r[9], r[10], 1);
        end
        send_random(9'd128, 1'b0, 1'b0, 2);
        if (i_check.accepts - acc0 != 6)
            i_check.note_error($sformatf("%0d draws taken, 6 sent", i_check.accepts - acc0));
        line_end(1'b0);

        i_check.begin_test("wrap_flip");
        send_random(9'd505, 1'b0, 1'b0, 1);          // runs past 511 into 0..8
        line_end(1'b0);
        send_random(9'd20, 1'b1, 1'b0, 1);
        send_random(9'd500, 1'b0, 1'b1, 1);
        line_end(1'b1);                              // mirrored read

        if (i_check.compares != sweeps * `OBJ_BUF_DEPTH)
            i_check.note_error($sformatf("%0d pixels compared, %0d expected",
                                         i_check.compares, sweeps * `OBJ_BUF_DEPTH));
        $display("pixels %0d, mismatches %0d, other errors %0d",
                 i_check.compares, i_check.mismatches, i_check.other_errs);
        if (i_check.mismatches + i_check.other_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (N_TESTS * 1200) @(posedge clk);
        $display("timeout, run still going after %0d cycles", N_TESTS * 1200);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== sim/obj_draw_checker.sv ====
`include "obj_draw_macros.svh"

// watches the sprite drawer ports, keeps a model of both line banks
// and compares every streamed pixel with it
module obj_draw_checker (
    input  logic               clk,
    input  logic               rst,
    input  logic               draw,
    input  logic               busy,
    input  obj_pkg::code_t     code,
    input  video_pkg::hpos_t   xpos,
    input  obj_pkg::row_t      ysub,
    input  logic               hflip,
    input  logic               vflip,
    input  obj_pkg::pal_t      pal,
    input  logic               rom_cs,
    input  logic               hs,
    input  logic               flip,
    input  logic               pxl_cen,
    input  video_pkg::hpos_t   hdump,
    input  video_pkg::pixel_t  pxl
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ROM_WAIT_MAX = 5;                         // slowest rom answer in the tb
    localparam int BUSY_MIN = 2 + `OBJ_SPR_W;                // two fetches, 16 writes
    localparam int BUSY_MAX = BUSY_MIN + 2 * ROM_WAIT_MAX;

    video_pkg::pixel_t model [2][`OBJ_BUF_DEPTH];            // expected bank contents
    int                wr_bank;                              // model bank taking draws
    logic              hs_l;
    logic              pend;                                 // a read happened at the last edge
    video_pkg::pixel_t exp_pxl;
    video_pkg::hpos_t  exp_pos;
    int                busy_len;
    int                busy_cs;                              // rom_cs cycles inside busy
    int                cs_len;

    string test_name = "reset";
    int    accepts    = 0;
    int    compares   = 0;
    int    mismatches = 0;
    int    other_errs = 0;

    // gfx rom content, a hash of the word address
    function automatic logic [31:0] rom_word(input obj_pkg::rom_addr_t a);
        logic [31:0] h;
        h = 32'(a) * 32'h9e3779b1;
        h = h ^ (h >> 15);
        h = h * 32'h85ebca6b;
        h = h ^ (h >> 13);
        for (int i = 0; i < 8; i++) begin
            if (h[4*i +: 4] >= 4'd13) h[4*i +: 4] = `OBJ_TRANSP;  // more holes to test
        end
        return h;
    endfunction

    // pixel that a command puts at screen position xpos + k
    function automatic video_pkg::pixel_t draw_ref(input obj_pkg::code_t c,
            input obj_pkg::row_t y, input logic hf, input logic vf,
            input obj_pkg::pal_t p, input int k);
        int          s;
        logic [3:0]  row;
        logic [31:0] w;
        row = vf ? 4'd15 - y : y;                    // vflip counts rows from the bottom
        s = hf ? 15 - k : k;                         // sprite pixel shown at k
        w = rom_word({c, row, s >= 8});              // half 1 holds pixels 8..15
        return {p, w[31 - 4 * (s % 8) -: 4]};        // leftmost pixel in the top nibble
    endfunction

    task automatic begin_test(input string name);
        test_name = name;
        $display("-- test %s", name);
    endtask

    task automatic note_error(input string msg);
        $display("ERROR in %s: %s", test_name, msg);
        other_errs++;
    endtask

    always @(posedge clk) begin
        video_pkg::hpos_t  ra;
        video_pkg::pixel_t px;
        if (rst) begin
            for (int b = 0; b < 2; b++) begin
                for (int i = 0; i < `OBJ_BUF_DEPTH; i++) model[b][i] = video_pkg::PXL_BLANK;
            end
            wr_bank  = 0;
            hs_l     = 1'b0;
            pend     = 1'b0;
            busy_len = 0;
            busy_cs  = 0;
            cs_len   = 0;
        end else begin
            pend = pxl_cen;
            if (pxl_cen) begin                       // read bank is the one not drawn
                ra = flip ? video_pkg::hpos_t'(`OBJ_BUF_DEPTH - 1) - hdump : hdump;
                exp_pxl = model[1 - wr_bank][ra];
                exp_pos = hdump;
                model[1 - wr_bank][ra] = video_pkg::PXL_BLANK;   // erased behind the read
            end
            if (hs && !hs_l) wr_bank = 1 - wr_bank;  // line start swaps the banks
            hs_l = hs;
            if (draw && !busy) begin                 // accepted command
                accepts++;
                for (int k = 0; k < `OBJ_SPR_W; k++) begin
                    px = draw_ref(code, ysub, hflip, vflip, pal, k);
                    if (px[3:0] != `OBJ_TRANSP) model[wr_bank][xpos + 9'(k)] = px;
                end
            end
            if (busy) begin
                busy_len++;
                if (rom_cs) busy_cs++;
                if (busy_len == BUSY_MAX + 1)
                    note_error($sformatf("busy held for more than %0d cycles", BUSY_MAX));
            end else begin
                // fetch cycles, rom waits included, plus one cycle per pixel
                if (busy_len != 0 && busy_len != busy_cs + `OBJ_SPR_W)
                    note_error($sformatf("busy high %0d cycles, fetches and writes need %0d",
                                         busy_len, busy_cs + `OBJ_SPR_W));
                busy_len = 0;
                busy_cs  = 0;
            end
            cs_len = rom_cs ? cs_len + 1 : 0;
            if (cs_len == ROM_WAIT_MAX + 2)
                note_error("rom_cs stayed high after the rom had answered");
        end
    end

    // pxl settles at the edge after the read, compared half a cycle later
    always @(negedge clk) begin
        if (!rst && pend) begin
            compares++;
            if (pxl !== exp_pxl) begin
                mismatches++;
                $display("MISMATCH %s hdump %0d expected %02h actual %02h",
                         test_name, exp_pos, exp_pxl, pxl);
            end
        end
    end

endmodule

// ==== rtl/obj_draw_top.sv ====
`include "obj_draw_macros.svh"

// sprite drawing front end: command latch, drawer and line buffer
// LATCH=1 registers the command while idle, one extra clock per sprite
// HJUMP=1 suits an hdump that runs 000-0ff then 180-1ff
module obj_draw_top #(
    parameter int LATCH = 0,
    parameter int HJUMP = 0
) (
    input  logic                clk,
    input  logic                rst,
    // video timing
    input  logic                pxl_cen,
    input  logic                hs,
    input  logic                flip,
    input  video_pkg::hpos_t    hdump,
    // draw command
    input  logic                draw,
    input  obj_pkg::code_t      code,
    input  video_pkg::hpos_t    xpos,
    input  obj_pkg::row_t       ysub,
    input  logic                hflip,
    input  logic                vflip,
    input  obj_pkg::pal_t       pal,
    output logic                busy,
    // gfx rom
    output obj_pkg::rom_addr_t  rom_addr,
    output logic                rom_cs,
    input  logic                rom_ok,
    input  logic [31:0]         rom_data,
    // sprite layer pixel
    output video_pkg::pixel_t   pxl
);

    // command as seen by the drawer
    logic              dr_draw;
    obj_pkg::code_t    dr_code;
    video_pkg::hpos_t  dr_xpos;
    obj_pkg::row_t     dr_ysub;
    logic              dr_hflip;
    logic              dr_vflip;
    obj_pkg::pal_t     dr_pal;

    logic              buf_we;
    video_pkg::hpos_t  buf_addr;
    video_pkg::hpos_t  aeff;        // buffer address after hjump
    video_pkg::pixel_t buf_din;

    generate
        if (LATCH != 0) begin : g_latch
            // one-shot, a held draw is taken again only after busy falls
            always_ff @(posedge clk) begin
                if (rst) begin
                    dr_draw <= 1'b0;
                end else if (!busy) begin
                    dr_draw <= draw && !dr_draw;
                end
            end
            always_ff @(posedge clk) begin
                if (!busy) begin    // frozen while drawing
                    dr_code  <= code;
                    dr_xpos  <= xpos;
                    dr_ysub  <= ysub;
                    dr_hflip <= hflip;
                    dr_vflip <= vflip;
                    dr_pal   <= pal;
                end
            end
        end else begin : g_direct
            // inputs must hold until busy falls
            always_comb begin
                dr_draw  = draw;
                dr_code  = code;
                dr_xpos  = xpos;
                dr_ysub  = ysub;
                dr_hflip = hflip;
                dr_vflip = vflip;
                dr_pal   = pal;
            end
        end
    endgenerate

    // 100-17f lands on 180-1ff so draw and read positions agree
    assign aeff = HJUMP != 0 ? {buf_addr[8], buf_addr[8] | buf_addr[7], buf_addr[6:0]}
                             : buf_addr;

    obj_tile_draw i_obj_tile_draw (
        .clk      (clk),
        .rst      (rst),
        .draw     (dr_draw),
        .code     (dr_code),
        .xpos     (dr_xpos),
        .ysub     (dr_ysub),
        .hflip    (dr_hflip),
        .vflip    (dr_vflip),
        .pal      (dr_pal),
        .busy     (busy),
        .rom_addr (rom_addr),
        .rom_cs   (rom_cs),
        .rom_ok   (rom_ok),
        .rom_data (rom_data),
        .buf_we   (buf_we),
        .buf_addr (buf_addr),
        .buf_din  (buf_din)
    );

    obj_line_buffer i_obj_line_buffer (
        .clk      (clk),
        .rst      (rst),
        .hs       (hs),
        .flip     (flip),
        .rd       (pxl_cen),  // one read per pixel
        .rd_addr  (hdump),
        .rd_data  (pxl),
        .we       (buf_we),
        .wr_addr  (aeff),
        .wr_data  (buf_din)
    );

endmodule

// ==== rtl/obj_line_buffer.sv ====
`include "obj_draw_macros.svh"

// two line banks: one is drawn for the next line, the other
// streams out the current line and erases behind the read
module obj_line_buffer (
    input  logic                clk,
    input  logic                rst,
    input  logic                hs,         // banks swap on the rising edge
    input  logic                flip,       // screen flip, mirrors the read
    // read side, video out
    input  logic                rd,
    input  video_pkg::hpos_t    rd_addr,
    output video_pkg::pixel_t   rd_data,
    // write side, drawer
    input  logic                we,
    input  video_pkg::hpos_t    wr_addr,
    input  video_pkg::pixel_t   wr_data
);

    video_pkg::bank_t  bank;        // bank taking writes this line
    logic              hs_l;
    logic              hs_rise;
    video_pkg::hpos_t  ra;          // effective read address
    logic [1:0]        wr_sel;      // one-hot write enable, bit 0 is bank A
    logic [1:0]        rd_sel;      // one-hot read enable

    video_pkg::pixel_t mem_a [`OBJ_BUF_DEPTH];
    video_pkg::pixel_t mem_b [`OBJ_BUF_DEPTH];
    // per-location flags, a cleared flag reads as all ones
    logic [`OBJ_BUF_DEPTH-1:0] vld_a;
    logic [`OBJ_BUF_DEPTH-1:0] vld_b;

    assign hs_rise = hs && !hs_l;

    // 511 - hdump under flip
    assign ra = flip ? video_pkg::hpos_t'(`OBJ_BUF_DEPTH - 1) - rd_addr : rd_addr;

    assign wr_sel = {we && bank == video_pkg::BANK_B, we && bank == video_pkg::BANK_A};
    assign rd_sel = {rd && bank == video_pkg::BANK_A, rd && bank == video_pkg::BANK_B};

    always_ff @(posedge clk) begin
        if (rst) begin
            hs_l <= 1'b0;
            bank <= video_pkg::BANK_A;
        end else begin
            hs_l <= hs;
            if (hs_rise) begin
                bank <= bank == video_pkg::BANK_A ? video_pkg::BANK_B : video_pkg::BANK_A;
            end
        end
    end

    // pixel storage
    always_ff @(posedge clk) begin
        if (wr_sel[0]) mem_a[wr_addr] <= wr_data;
        if (wr_sel[1]) mem_b[wr_addr] <= wr_data;
    end

    // occupancy: set by a draw, cleared by the read that follows
    always_ff @(posedge clk) begin
        if (rst) begin
            vld_a <= '0;    // both banks empty after reset
            vld_b <= '0;
        end else begin
            if (wr_sel[0]) vld_a[wr_addr] <= 1'b1;
            if (rd_sel[0]) vld_a[ra]      <= 1'b0;  // erase after read
            if (wr_sel[1]) vld_b[wr_addr] <= 1'b1;
            if (rd_sel[1]) vld_b[ra]      <= 1'b0;
        end
    end

    // registered read, pixel shows up one clock after rd
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_data <= video_pkg::PXL_BLANK;
        end else if (rd_sel[0]) begin
            rd_data <= vld_a[ra] ? mem_a[ra] : video_pkg::PXL_BLANK;
        end else if (rd_sel[1]) begin
            rd_data <= vld_b[ra] ? mem_b[ra] : video_pkg::PXL_BLANK;
        end
    end

    // a draw still writing at the swap would land in the bank about to be read
    a_bank_sep: assert property (
        @(posedge clk) disable iff (rst)
        hs_rise |-> !we
    ) else $error("write at the line swap lands in the bank about to be read");

endmodule

// ==== rtl/obj_tile_draw.sv ====
`include "obj_draw_macros.svh"

// fetches one 16-pixel sprite row as two rom words and writes
// the opaque pixels into the line buffer, one per clock
module obj_tile_draw (
    input  logic                clk,
    input  logic                rst,
    // draw command
    input  logic                draw,
    input  obj_pkg::code_t      code,
    input  video_pkg::hpos_t    xpos,
    input  obj_pkg::row_t       ysub,
    input  logic                hflip,
    input  logic                vflip,
    input  obj_pkg::pal_t       pal,
    output logic                busy,
    // gfx rom
    output obj_pkg::rom_addr_t  rom_addr,
    output logic                rom_cs,
    input  logic                rom_ok,
    input  logic [31:0]         rom_data,
    // line buffer write
    output logic                buf_we,
    output video_pkg::hpos_t    buf_addr,
    output video_pkg::pixel_t   buf_din
);

    obj_pkg::draw_state_t state;
    obj_pkg::half_t       half;       // half currently fetched or written
    obj_pkg::half_t       first_half; // half to start with, from hflip
    obj_pkg::row_t        row;        // sprite row after vflip
    obj_pkg::code_t       code_r;
    obj_pkg::row_t        row_r;
    obj_pkg::pal_t        pal_r;
    obj_pkg::nibble_t     nib;        // pixel on its way out
    logic                 hf;         // latched hflip
    logic [31:0]          sr;         // fetched word, shifted one nibble per write
    logic [2:0]           cnt;        // pixel within the half
    logic                 last_pxl;
    logic                 last_half;

    // vflip reads the rows bottom up
    assign row = vflip ? obj_pkg::row_t'(`OBJ_SPR_W - 1) - ysub : ysub;

    // hflip starts on the right half and walks it backwards
    assign first_half = hflip ? obj_pkg::HALF_RIGHT : obj_pkg::HALF_LEFT;

    assign last_pxl  = cnt == 3'(`OBJ_SPR_W / 2 - 1);
    assign last_half = half == (hf ? obj_pkg::HALF_LEFT : obj_pkg::HALF_RIGHT);

    // leftmost pixel sits in bits 31:28, hflip takes bits 3:0 first
    assign nib = hf ? sr[3:0] : sr[31:28];

    assign busy     = state != obj_pkg::IDLE;
    assign rom_cs   = state == obj_pkg::FETCH;  // addr is stable for the whole state
    assign rom_addr = {code_r, row_r, half};

    assign buf_din = {pal_r, nib};
    assign buf_we  = state == obj_pkg::WRITE && nib != `OBJ_TRANSP; // skip transparent

    // control
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= obj_pkg::IDLE;
            half  <= obj_pkg::HALF_LEFT;
            cnt   <= '0;
        end else begin
            case (state)
                obj_pkg::IDLE: begin
                    if (draw) begin     // busy is low here, so this is the accept edge
                        state <= obj_pkg::FETCH;
                        half  <= first_half;
                    end
                end
                obj_pkg::FETCH: begin
                    if (rom_ok) begin   // only wait point, rom_cs held until now
                        state <= obj_pkg::WRITE;
                        cnt   <= '0;
                    end
                end
                obj_pkg::WRITE: begin
                    cnt <= cnt + 3'd1;
                    if (last_pxl) begin
                        if (last_half) begin
                            state <= obj_pkg::IDLE;     // busy drops next cycle
                        end else begin
                            state <= obj_pkg::FETCH;
                            half  <= half == obj_pkg::HALF_LEFT ? obj_pkg::HALF_RIGHT
                                                                : obj_pkg::HALF_LEFT;
                        end
                    end
                end
                default: state <= obj_pkg::IDLE;
            endcase
        end
    end

    // command copy and pixel data path
    always_ff @(posedge clk) begin
        if (state == obj_pkg::IDLE && draw) begin
            code_r   <= code;
            row_r    <= row;
            pal_r    <= pal;
            hf       <= hflip;
            buf_addr <= xpos;
        end
        if (state == obj_pkg::FETCH && rom_ok) begin
            sr <= rom_data;
        end
        if (state == obj_pkg::WRITE) begin
            sr       <= hf ? {4'd0, sr[31:4]} : {sr[27:0], 4'd0};
            buf_addr <= buf_addr + 1'b1;    // wraps modulo 512
        end
    end

    // rom request must not move until it is answered
    a_rom_hold: assert property (
        @(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr)
    ) else $error("rom_addr changed while a fetch was pending");

    // each fetched word is written out in exactly eight cycles
    a_we_write: assert property (
        @(posedge clk) disable iff (rst)
        state == obj_pkg::WRITE && last_pxl |->
            $past(state, 7) == obj_pkg::WRITE && $past(state, 8) == obj_pkg::FETCH
    ) else $error("write phase is not eight pixels after a fetch");

endmodule

// ==== rtl/video_pkg.sv ====
`include "obj_draw_macros.svh"

package video_pkg;

    // bank that takes writes during the current line
    // the other one is streamed out and erased
    typedef enum logic {
        BANK_A = 1'b0,
        BANK_B = 1'b1
    } bank_t;

    typedef logic [`OBJ_PW-1:0]     pixel_t;  // {pal, colour}
    typedef logic [`OBJ_BUF_AW-1:0] hpos_t;   // horizontal position, wraps at 512

    // value of an empty location, reads back as transparent everywhere
    localparam pixel_t PXL_BLANK = '1;

endpackage

// ==== rtl/obj_pkg.sv ====
`include "obj_draw_macros.svh"

package obj_pkg;

    // drawer sequencing
    typedef enum logic [1:0] {
        IDLE,   // waiting for draw
        FETCH,  // rom_cs up, waiting on rom_ok
        WRITE   // pushing 8 pixels into the line buffer
    } draw_state_t;

    // which 8-pixel half of the sprite row is on the rom bus
    typedef enum logic {
        HALF_LEFT  = 1'b0,
        HALF_RIGHT = 1'b1
    } half_t;

    typedef logic [`OBJ_CW-1:0]     code_t;     // sprite code
    typedef logic [3:0]             row_t;      // row inside the sprite, 0..15
    typedef logic [3:0]             nibble_t;   // one rom pixel
    typedef logic [`OBJ_PW-5:0]     pal_t;      // palette, upper pixel bits
    typedef logic [`OBJ_ROM_AW-1:0] rom_addr_t;

endpackage

// ==== include/obj_draw_macros.svh ====
`ifndef OBJ_DRAW_MACROS_SVH
`define OBJ_DRAW_MACROS_SVH

// sprite code width, selects one 16x16 object in the gfx rom
`define OBJ_CW 12

// output pixel: low nibble colour, high nibble palette
`define OBJ_PW 8

// sprite is square, this many pixels per side
`define OBJ_SPR_W 16

// rom word address = {code, row, half}
`define OBJ_ROM_AW (`OBJ_CW + 5)

// line buffer addressing, 512 positions per bank
`define OBJ_BUF_AW 9
`define OBJ_BUF_DEPTH 512

// colour nibble that is never drawn
`define OBJ_TRANSP 4'hf

`endif
